//--- cache_layer.f
verilog/bus_pkg.sv
verilog/cache_pkg.sv
verilog/req_slice.sv
verilog/line_buffer.sv
verilog/data_port.sv
verilog/mem_arbiter.sv
verilog/cache_layer.sv
verification/mem_model.sv
verification/cache_layer_tb.sv

//--- verification/cache_layer_tb.sv
module cache_layer_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS  = 1024;
    localparam int LINE_WORDS = cache_pkg::LINE_WORDS;
    localparam int LIMIT      = 200;  // Cycles allowed for any one wait.

    logic                       aclk;
    logic                       rst;
    logic                       i_req;
    bus_pkg::addr_t             i_addr;
    logic                       i_ack;
    bus_pkg::word_t             i_rdata;
    logic                       d_req;
    bus_pkg::addr_t             d_addr;
    logic                       d_we;
    bus_pkg::word_t             d_wdata;
    bus_pkg::size_t             d_size;
    logic                       d_signed;
    logic                       d_ack;
    bus_pkg::word_t             d_rdata;
    logic                       mem_req;
    bus_pkg::addr_t             mem_addr;
    logic                       mem_we;
    bus_pkg::word_t             mem_wdata;
    logic [bus_pkg::STRB_W-1:0] mem_strb;
    logic                       mem_burst;
    logic                       mem_beat;
    bus_pkg::word_t             mem_rdata;
    logic                       mem_ack;

    bus_pkg::word_t shadow [MEM_WORDS];
    bus_pkg::word_t i_exp [$];
    bus_pkg::word_t d_exp [$];
    bit             d_chk [$];
    int             checks;
    int             errors;
    int             mark_checks;
    int             mark_errors;
    int             bursts;
    logic           i_ack_q, d_ack_q, i_req_q, d_req_q, mem_req_q;
    logic           i_wait, d_wait;
    int             i_others, d_others;

    cache_layer #(.LINE_WORDS(LINE_WORDS)) dut_i (
        .aclk, .rst,
        .i_req, .i_addr, .i_ack, .i_rdata,
        .d_req, .d_addr, .d_we, .d_wdata, .d_size, .d_signed, .d_ack, .d_rdata,
        .mem_req, .mem_addr, .mem_we, .mem_wdata, .mem_strb, .mem_burst,
        .mem_beat, .mem_rdata, .mem_ack
    );

    mem_model #(.WORDS(MEM_WORDS), .LINE_WORDS(LINE_WORDS)) mem_i (
        .aclk, .rst,
        .mem_req, .mem_addr, .mem_we, .mem_wdata, .mem_strb, .mem_burst,
        .mem_beat, .mem_rdata, .mem_ack
    );

    always #2 aclk = ~aclk;

    // ####################
    // Reference model
    // ####################

    function automatic bus_pkg::word_t fill_word(int idx);
        return (32'h9e37_79b9 * (idx + 1)) ^ {idx[15:0], ~idx[15:0]};
    endfunction

    function automatic bus_pkg::word_t ref_load(bus_pkg::addr_t a, bus_pkg::size_t sz,
                                                logic sgn);
        bus_pkg::word_t w;
        w = shadow[a[11:2]] >> (8 * a[1:0]);  // Addressed lane moves to bit 0.
        case (sz)
            bus_pkg::SIZE_BYTE: return sgn ? {{24{w[7]}}, w[7:0]} : {24'h0, w[7:0]};
            bus_pkg::SIZE_HALF: return sgn ? {{16{w[15]}}, w[15:0]} : {16'h0, w[15:0]};
            default:            return w;
        endcase
    endfunction

    function automatic void write_shadow(bus_pkg::addr_t a, bus_pkg::size_t sz,
                                         bus_pkg::word_t data);
        int lane;
        lane = int'(a[1:0]);
        case (sz)
            bus_pkg::SIZE_BYTE: shadow[a[11:2]][8*lane +: 8] = data[7:0];
            bus_pkg::SIZE_HALF: shadow[a[11:2]][8*lane +: 16] = data[15:0];
            default:            shadow[a[11:2]] = data;
        endcase
    endfunction

    task automatic abort_run(string what);
        $display("%s", what);
        $display("Something failed");
        $finish;
    endtask

    task automatic finish_test(string name);
        $display("[TEST] %-20s %0d checks, %0d errors", name,
                 checks - mark_checks, errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    // ####################
    // Processor side
    // ####################

    task automatic fetch(bus_pkg::addr_t a, int hold);
        int n;
        @(posedge aclk);
        i_exp.push_back(shadow[a[11:2]]);
        i_req  <= 1'b1;
        i_addr <= a;
        n = 0;
        while (!i_ack) begin
            @(posedge aclk);
            n++;
            if (n > LIMIT) abort_run($sformatf("Fetch at %h never got i_ack", a));
        end
        repeat (hold) @(posedge aclk);
        i_req <= 1'b0;
        n = 0;
        while (i_ack) begin
            @(posedge aclk);
            n++;
            if (n > LIMIT) abort_run($sformatf("i_ack stuck high after fetch at %h", a));
        end
    endtask

    task automatic data_access(bus_pkg::addr_t a, logic we, bus_pkg::word_t wd,
                               bus_pkg::size_t sz, logic sgn, int hold);
        int n;
        @(posedge aclk);
        d_chk.push_back(!we);
        if (we) begin
            write_shadow(a, sz, wd);
            d_exp.push_back('0);
        end else begin
            d_exp.push_back(ref_load(a, sz, sgn));
        end
        d_req    <= 1'b1;
        d_addr   <= a;
        d_we     <= we;
        d_wdata  <= wd;
        d_size   <= sz;
        d_signed <= sgn;
        n = 0;
        while (!d_ack) begin
            @(posedge aclk);
            n++;
            if (n > LIMIT) abort_run($sformatf("Data access at %h never got d_ack", a));
        end
        repeat (hold) @(posedge aclk);
        d_req <= 1'b0;
        n = 0;
        while (d_ack) begin
            @(posedge aclk);
            n++;
            if (n > LIMIT) abort_run($sformatf("d_ack stuck high after access at %h", a));
        end
    endtask

    // ####################
    // Checkers
    // ####################

    task automatic check_order(string port, logic req, logic ack, logic ack_q);
        if (ack != ack_q) begin
            checks++;
        end
        if (ack && !ack_q && !req) begin
            $display("At %0t %s_ack rose while %s_req was low", $time, port, port);
            errors++;
        end
        if (!ack && ack_q && req) begin
            $display("At %0t %s_ack fell while %s_req was still high", $time, port, port);
            errors++;
        end
    endtask

    always @(posedge aclk) begin : compare
        bus_pkg::word_t e;
        bit             c;
        if (rst) begin
            i_ack_q <= 1'b0;
            d_ack_q <= 1'b0;
        end else begin
            i_ack_q <= i_ack;
            d_ack_q <= d_ack;
            check_order("i", i_req, i_ack, i_ack_q);
            check_order("d", d_req, d_ack, d_ack_q);
            if (i_ack && !i_ack_q && i_exp.size() > 0) begin
                e = i_exp.pop_front();
                checks++;
                if (i_rdata !== e) begin
                    $display("[ERROR] %0t i_rdata got %h expected %h", $time, i_rdata, e);
                    errors++;
                end
            end
            if (d_ack && !d_ack_q && d_exp.size() > 0) begin
                e = d_exp.pop_front();
                c = d_chk.pop_front();
                if (c) begin
                    checks++;
                    if (d_rdata !== e) begin
                        $display("[ERROR] %0t d_rdata got %h expected %h", $time, d_rdata, e);
                        errors++;
                    end
                end
            end
        end
    end

    // Counts memory transactions of the other path while one path waits.
    always @(posedge aclk) begin : fairness
        logic start;
        if (rst) begin
            mem_req_q <= 1'b0;
            i_req_q   <= 1'b0;
            d_req_q   <= 1'b0;
            bursts    <= 0;
            i_wait = 1'b0;
            d_wait = 1'b0;
        end else begin
            start = mem_req && !mem_req_q;
            mem_req_q <= mem_req;
            i_req_q   <= i_req;
            d_req_q   <= d_req;
            if (start && mem_burst) begin
                bursts <= bursts + 1;
            end
            if (start && (i_wait || d_wait)) begin
                // Only the instruction path issues bursts.
                if (mem_burst) begin
                    if (d_wait) begin
                        d_others++;
                    end
                    i_wait = 1'b0;
                end else begin
                    if (i_wait) begin
                        i_others++;
                    end
                    d_wait = 1'b0;
                end
                if (i_others > 1 || d_others > 1) begin
                    $display("At %0t a path waited behind two grants of the other path", $time);
                    errors++;
                end
            end
            if (i_ack) i_wait = 1'b0;
            if (d_ack) d_wait = 1'b0;
            if (i_req && !i_req_q) begin
                i_wait   = 1'b1;
                i_others = 0;
            end
            if (d_req && !d_req_q) begin
                d_wait   = 1'b1;
                d_others = 0;
            end
        end
    end

    // ####################
    // Test sequence
    // ####################

    initial begin : main
        bus_pkg::addr_t a;
        bus_pkg::addr_t touched [$];
        bus_pkg::size_t sz;
        int             seed;
        int             b0;
        aclk = 1'b0;
        rst      <= 1'b1;
        i_req    <= 1'b0;
        i_addr   <= '0;
        d_req    <= 1'b0;
        d_addr   <= '0;
        d_we     <= 1'b0;
        d_wdata  <= '0;
        d_size   <= bus_pkg::SIZE_WORD;
        d_signed <= 1'b0;
        checks = 0;
        errors = 0;
        mark_checks = 0;
        mark_errors = 0;
        seed = 32'h4d9c;
        void'($urandom(seed));
        for (int k = 0; k < MEM_WORDS; k++) begin
            shadow[k] = fill_word(k);
            mem_i.words[k] = fill_word(k);
        end
        repeat (16) @(posedge aclk);
        rst <= 1'b0;

        b0 = bursts;
        for (int k = 0; k < LINE_WORDS; k++) fetch(32'h100 + 4 * k, 0);
        checks++;
        if (bursts - b0 != 1) begin
            $display("[ERROR] %0t mem_burst count got %0d expected 1", $time, bursts - b0);
            errors++;
        end
        finish_test("line fetch");

        b0 = bursts;
        fetch(32'h204, 0);
        fetch(32'h10c, 0);  // Old line was evicted.
        checks++;
        if (bursts - b0 != 2) begin
            $display("[ERROR] %0t mem_burst count got %0d expected 2", $time, bursts - b0);
            errors++;
        end
        finish_test("line miss");

        for (int k = 0; k < 16; k++) begin
            a  = 32'h800 + ($urandom % 256) * 4;
            sz = bus_pkg::size_t'($urandom % 3);
            if (sz == bus_pkg::SIZE_BYTE) a = a + ($urandom % 4);
            if (sz == bus_pkg::SIZE_HALF) a = a + 2 * ($urandom % 2);
            data_access(a, 1'b1, $urandom, sz, 1'b0, 0);
            touched.push_back({a[31:2], 2'b00});
        end
        foreach (touched[k]) data_access(touched[k], 1'b0, '0, bus_pkg::SIZE_WORD, 1'b0, 0);
        finish_test("strobed stores");

        data_access(32'h900, 1'b1, 32'h807f_ff01, bus_pkg::SIZE_WORD, 1'b0, 0);
        data_access(32'h904, 1'b1, 32'h7f80_01ff, bus_pkg::SIZE_WORD, 1'b0, 0);
        data_access(32'h908, 1'b1, $urandom, bus_pkg::SIZE_WORD, 1'b0, 0);
        for (int w = 0; w < 3; w++) begin
            for (int off = 0; off < 4; off++) begin
                for (int s = 0; s < 2; s++) begin
                    a = 32'h900 + 4 * w + off;
                    data_access(a, 1'b0, '0, bus_pkg::SIZE_BYTE, s[0], 0);
                    if (off % 2 == 0) data_access(a, 1'b0, '0, bus_pkg::SIZE_HALF, s[0], 0);
                end
            end
        end
        finish_test("load extension");

        fork
            for (int k = 0; k < 8; k++) fetch(32'h40 * (k % 3) + 4 * (k % 4), 0);
            for (int k = 0; k < 8; k++) begin
                if (k % 2 == 0) data_access(32'ha00 + 4 * k, 1'b1, $urandom,
                                            bus_pkg::SIZE_WORD, 1'b0, 0);
                else data_access(32'ha00 + 4 * (k - 1), 1'b0, '0, bus_pkg::SIZE_WORD, 1'b0, 0);
            end
        join
        finish_test("concurrent paths");

        fetch(32'h300, 3);
        fetch(32'h304, 3);  // A hit, with req held late.
        data_access(32'h904, 1'b0, '0, bus_pkg::SIZE_HALF, 1'b1, 3);
        data_access(32'h90c, 1'b1, 32'hcafe_f00d, bus_pkg::SIZE_WORD, 1'b0, 3);
        data_access(32'h90c, 1'b0, '0, bus_pkg::SIZE_WORD, 1'b0, 3);
        finish_test("four-phase order");

        if (i_exp.size() != 0 || d_exp.size() != 0) begin
            $display("Some requests finished without a result being checked");
            errors++;
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- verification/mem_model.sv
module mem_model #(
    parameter int WORDS      = 1024,
    parameter int LINE_WORDS = 4
) (
    input  logic                       aclk,
    input  logic                       rst,
    input  logic                       mem_req,
    input  bus_pkg::addr_t             mem_addr,
    input  logic                       mem_we,
    input  bus_pkg::word_t             mem_wdata,
    input  logic [bus_pkg::STRB_W-1:0] mem_strb,
    input  logic                       mem_burst,
    output logic                       mem_beat,
    output bus_pkg::word_t             mem_rdata,
    output logic                       mem_ack
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int IDX_W = $clog2(WORDS);

    bus_pkg::word_t   words [WORDS];
    logic             busy;
    int               base;
    int               cnt;
    logic [IDX_W-1:0] idx;

    assign idx = mem_addr[IDX_W+1:2];

    initial begin
        mem_beat  <= 1'b0;
        mem_ack   <= 1'b0;
        mem_rdata <= '0;
    end

    always @(posedge aclk) begin
        if (rst) begin
            busy     <= 1'b0;
            mem_beat <= 1'b0;
            mem_ack  <= 1'b0;
            cnt      <= 0;
        end else begin
            mem_beat <= 1'b0;
            if (mem_ack) begin
                if (!mem_req) begin
                    mem_ack <= 1'b0;  // Requester has let go.
                end
            end else if (busy) begin
                mem_beat  <= 1'b1;
                mem_rdata <= words[base + cnt];
                cnt       <= cnt + 1;
                if (cnt == LINE_WORDS - 1) begin
                    busy    <= 1'b0;
                    mem_ack <= 1'b1;  // Ack rides on the last beat.
                end
            end else if (mem_req) begin
                if (mem_burst) begin
                    busy <= 1'b1;
                    cnt  <= 0;
                    base <= int'(idx) - (int'(idx) % LINE_WORDS);
                end else begin
                    mem_rdata <= words[idx];
                    for (int b = 0; b < bus_pkg::STRB_W; b++) begin
                        if (mem_we && mem_strb[b]) begin
                            words[idx][8*b +: 8] = mem_wdata[8*b +: 8];
                        end
                    end
                    mem_beat <= 1'b1;
                    mem_ack  <= 1'b1;
                end
            end
        end
    end

endmodule

//--- verilog/cache_layer.sv
module cache_layer #(
    parameter int LINE_WORDS = cache_pkg::LINE_WORDS
) (
    input  logic                       aclk,
    input  logic                       rst,

    input  logic                       i_req,
    input  bus_pkg::addr_t             i_addr,
    output logic                       i_ack,
    output bus_pkg::word_t             i_rdata,

    input  logic                       d_req,
    input  bus_pkg::addr_t             d_addr,
    input  logic                       d_we,
    input  bus_pkg::word_t             d_wdata,
    input  bus_pkg::size_t             d_size,
    input  logic                       d_signed,
    output logic                       d_ack,
    output bus_pkg::word_t             d_rdata,

    output logic                       mem_req,
    output bus_pkg::addr_t             mem_addr,
    output logic                       mem_we,
    output bus_pkg::word_t             mem_wdata,
    output logic [bus_pkg::STRB_W-1:0] mem_strb,
    output logic                       mem_burst,
    input  logic                       mem_beat,
    input  bus_pkg::word_t             mem_rdata,
    input  logic                       mem_ack
);

    bus_pkg::ireq_t             i_up, i_dn;
    bus_pkg::dreq_t             d_up, d_dn;
    logic                       i_dn_req, i_dn_ack;
    logic                       d_dn_req, d_dn_ack;

    logic                       lb_mreq, lb_mbeat, lb_mack;
    bus_pkg::addr_t             lb_maddr;
    bus_pkg::word_t             lb_mrdata;

    logic                       dp_mreq, dp_mwe, dp_mack;
    bus_pkg::addr_t             dp_maddr;
    bus_pkg::word_t             dp_mwdata, dp_mrdata;
    logic [bus_pkg::STRB_W-1:0] dp_mstrb;

    assign i_up.addr  = i_addr;
    assign d_up.addr  = d_addr;
    assign d_up.we    = d_we;
    assign d_up.wdata = d_wdata;
    assign d_up.size  = d_size;
    assign d_up.sgn   = d_signed;

    // ####################
    // Instruction path
    // ####################

    req_slice #(.payload_t(bus_pkg::ireq_t)) islice_inst (
        .aclk, .rst,
        .up_req(i_req), .up_payload(i_up), .up_ack(i_ack),
        .dn_req(i_dn_req), .dn_payload(i_dn), .dn_ack(i_dn_ack)
    );

    line_buffer #(.LINE_WORDS(LINE_WORDS)) ibuf_inst (
        .aclk, .rst,
        .req(i_dn_req), .addr(i_dn.addr), .ack(i_dn_ack), .rdata(i_rdata),
        .mreq(lb_mreq), .maddr(lb_maddr), .mbeat(lb_mbeat),
        .mrdata(lb_mrdata), .mack(lb_mack)
    );

    // ####################
    // Data path
    // ####################

    req_slice #(.payload_t(bus_pkg::dreq_t)) dslice_inst (
        .aclk, .rst,
        .up_req(d_req), .up_payload(d_up), .up_ack(d_ack),
        .dn_req(d_dn_req), .dn_payload(d_dn), .dn_ack(d_dn_ack)
    );

    data_port dport_inst (
        .aclk, .rst,
        .req(d_dn_req), .addr(d_dn.addr), .we(d_dn.we), .wdata(d_dn.wdata),
        .size(d_dn.size), .sgn(d_dn.sgn), .ack(d_dn_ack), .rdata(d_rdata),
        .mreq(dp_mreq), .maddr(dp_maddr), .mwe(dp_mwe), .mwdata(dp_mwdata),
        .mstrb(dp_mstrb), .mack(dp_mack), .mrdata(dp_mrdata)
    );

    mem_arbiter #(.LINE_WORDS(LINE_WORDS)) arbiter_inst (
        .aclk, .rst,
        .ins_req(lb_mreq), .ins_addr(lb_maddr), .ins_ack(lb_mack),
        .ins_beat(lb_mbeat), .ins_rdata(lb_mrdata),
        .dat_req(dp_mreq), .dat_addr(dp_maddr), .dat_we(dp_mwe),
        .dat_wdata(dp_mwdata), .dat_strb(dp_mstrb), .dat_ack(dp_mack),
        .dat_beat(), .dat_rdata(dp_mrdata),
        .mem_req, .mem_addr, .mem_we, .mem_wdata, .mem_strb, .mem_burst,
        .mem_beat, .mem_rdata, .mem_ack
    );

endmodule

//--- verilog/mem_arbiter.sv
module mem_arbiter #(
    parameter int LINE_WORDS = 4
) (
    input  logic                       aclk,
    input  logic                       rst,

    input  logic                       ins_req,
    input  bus_pkg::addr_t             ins_addr,
    output logic                       ins_ack,
    output logic                       ins_beat,
    output bus_pkg::word_t             ins_rdata,

    input  logic                       dat_req,
    input  bus_pkg::addr_t             dat_addr,
    input  logic                       dat_we,
    input  bus_pkg::word_t             dat_wdata,
    input  logic [bus_pkg::STRB_W-1:0] dat_strb,
    output logic                       dat_ack,
    output logic                       dat_beat,
    output bus_pkg::word_t             dat_rdata,

    output logic                       mem_req,
    output bus_pkg::addr_t             mem_addr,
    output logic                       mem_we,
    output bus_pkg::word_t             mem_wdata,
    output logic [bus_pkg::STRB_W-1:0] mem_strb,
    output logic                       mem_burst,
    input  logic                       mem_beat,
    input  bus_pkg::word_t             mem_rdata,
    input  logic                       mem_ack
);

    localparam int CNT_W = $clog2(LINE_WORDS + 1);

    logic                gnt_ins;
    logic                gnt_dat;
    bus_pkg::src_t       last;
    logic [CNT_W-1:0]    beat_cnt;
    logic                beat_ok;

    // ####################
    // Grant
    // ####################

    always_ff @(posedge aclk) begin
        if (rst) begin
            gnt_ins <= 1'b0;
            gnt_dat <= 1'b0;
            last    <= bus_pkg::SRC_INSTR;  // So the data path wins the first tie.
        end else if (!gnt_ins && !gnt_dat) begin
            if (dat_req && (!ins_req || last == bus_pkg::SRC_INSTR)) begin
                gnt_dat <= 1'b1;
                last    <= bus_pkg::SRC_DATA;
            end else if (ins_req) begin
                gnt_ins <= 1'b1;
                last    <= bus_pkg::SRC_INSTR;
            end
        end else if (gnt_ins && !ins_req && !mem_ack) begin
            gnt_ins <= 1'b0;
        end else if (gnt_dat && !dat_req && !mem_ack) begin
            gnt_dat <= 1'b0;
        end
    end

    // ####################
    // Port mux
    // ####################

    assign mem_req   = (gnt_ins && ins_req) || (gnt_dat && dat_req);
    assign mem_addr  = gnt_ins ? ins_addr : dat_addr;
    assign mem_we    = gnt_dat && dat_we;
    assign mem_wdata = dat_wdata;
    assign mem_strb  = gnt_dat ? dat_strb : '0;
    assign mem_burst = gnt_ins;  // Instruction traffic is always a line refill.

    // Beats past the expected count are dropped so a path never overruns.
    always_ff @(posedge aclk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (!mem_req) begin
            beat_cnt <= '0;
        end else if (mem_beat && beat_ok) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    assign beat_ok = int'(beat_cnt) < (gnt_ins ? LINE_WORDS : 1);

    assign ins_beat  = gnt_ins && mem_beat && beat_ok;
    assign ins_ack   = gnt_ins && mem_ack;
    assign ins_rdata = mem_rdata;

    assign dat_beat  = gnt_dat && mem_beat && beat_ok;
    assign dat_ack   = gnt_dat && mem_ack;
    assign dat_rdata = mem_rdata;

    a_one_grant: assert property (
        @(posedge aclk) disable iff (rst)
        $onehot0({gnt_ins, gnt_dat})
    );

    // An ack from memory always belongs to a grant still being held.
    a_ack_owned: assert property (
        @(posedge aclk) disable iff (rst)
        mem_ack |-> $onehot({gnt_ins, gnt_dat})
    );

endmodule

//--- verilog/data_port.sv
module data_port (
    input  logic                       aclk,
    input  logic                       rst,

    input  logic                       req,
    input  bus_pkg::addr_t             addr,
    input  logic                       we,
    input  bus_pkg::word_t             wdata,
    input  bus_pkg::size_t             size,
    input  logic                       sgn,
    output logic                       ack,
    output bus_pkg::word_t             rdata,

    output logic                       mreq,
    output bus_pkg::addr_t             maddr,
    output logic                       mwe,
    output bus_pkg::word_t             mwdata,
    output logic [bus_pkg::STRB_W-1:0] mstrb,
    input  logic                       mack,
    input  bus_pkg::word_t             mrdata
);

    logic [1:0]                 lane;
    logic [bus_pkg::STRB_W-1:0] strb;
    bus_pkg::word_t             wlanes;
    bus_pkg::word_t             shifted;
    bus_pkg::word_t             ext;
    logic                       start;

    assign lane  = addr[1:0];
    assign start = req && !ack && !mreq && !mack;

    always_comb begin
        shifted = mrdata >> {lane, 3'b000};  // Bring the addressed lane down to bit 0.
        case (size)
            bus_pkg::SIZE_BYTE: begin
                strb   = 4'b0001 << lane;
                wlanes = {4{wdata[7:0]}};
                ext    = {{24{sgn & shifted[7]}}, shifted[7:0]};
            end
            bus_pkg::SIZE_HALF: begin
                strb   = 4'b0011 << lane;
                wlanes = {2{wdata[15:0]}};
                ext    = {{16{sgn & shifted[15]}}, shifted[15:0]};
            end
            default: begin
                strb   = 4'b1111;
                wlanes = wdata;
                ext    = shifted;
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            mreq <= 1'b0;
            ack  <= 1'b0;
        end else begin
            if (start) begin
                mreq <= 1'b1;
            end else if (mreq && mack) begin
                mreq <= 1'b0;
                ack  <= 1'b1;
            end else if (ack && !req) begin
                ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (start) begin
            maddr  <= {addr[bus_pkg::ADDR_W-1:2], 2'b00};
            mwe    <= we;
            mwdata <= wlanes;
            mstrb  <= strb;
        end
        if (mreq && mack) begin
            rdata <= ext;
        end
    end

    // Strobes never straddle a word, so a request may not either.
    a_aligned: assert property (
        @(posedge aclk) disable iff (rst)
        req |-> (size == bus_pkg::SIZE_WORD) ? (lane == 2'b00)
              : (size == bus_pkg::SIZE_HALF) ? !lane[0] : 1'b1
    );

endmodule

//--- verilog/line_buffer.sv
module line_buffer #(
    parameter int LINE_WORDS = 4
) (
    input  logic           aclk,
    input  logic           rst,

    input  logic           req,
    input  bus_pkg::addr_t addr,
    output logic           ack,
    output bus_pkg::word_t rdata,

    output logic           mreq,
    output bus_pkg::addr_t maddr,
    input  logic           mbeat,
    input  bus_pkg::word_t mrdata,
    input  logic           mack
);

    // The word select below is sized from the package geometry.
    if (LINE_WORDS != cache_pkg::LINE_WORDS) begin : g_geometry_check
        $error("line_buffer: LINE_WORDS differs from cache_pkg::LINE_WORDS");
    end

    logic [cache_pkg::TAG_BITS-1:0]  tag;
    logic                            valid;
    logic                            filling;
    logic [cache_pkg::WORD_BITS-1:0] fill_cnt;
    bus_pkg::word_t                  line [LINE_WORDS];

    logic [cache_pkg::TAG_BITS-1:0]  req_tag;
    logic [cache_pkg::WORD_BITS-1:0] req_word;
    logic                            hit;
    logic                            serve;
    logic                            refill;

    assign req_tag  = addr[bus_pkg::ADDR_W-1 -: cache_pkg::TAG_BITS];
    assign req_word = addr[cache_pkg::OFFSET_BITS-1:cache_pkg::BYTE_BITS];
    assign hit      = valid && (tag == req_tag);

    assign serve  = req && !ack && !filling && hit;
    assign refill = req && !ack && !filling && !hit && !mack;  // Wait for the old ack to fall.

    // ####################
    // Control
    // ####################

    always_ff @(posedge aclk) begin
        if (rst) begin
            valid    <= 1'b0;
            filling  <= 1'b0;
            fill_cnt <= '0;
            mreq     <= 1'b0;
            ack      <= 1'b0;
        end else begin
            if (serve) begin
                ack <= 1'b1;
            end else if (ack && !req) begin
                ack <= 1'b0;
            end

            if (refill) begin
                filling  <= 1'b1;
                mreq     <= 1'b1;
                valid    <= 1'b0;  // The line is overwritten from here on.
                fill_cnt <= '0;
            end else if (filling) begin
                if (mbeat) begin
                    fill_cnt <= fill_cnt + 1'b1;
                end
                if (mack) begin
                    // Last beat lands this cycle, the hit path answers next.
                    filling <= 1'b0;
                    mreq    <= 1'b0;
                    valid   <= 1'b1;
                end
            end
        end
    end

    // ####################
    // Tag, line and result
    // ####################

    always_ff @(posedge aclk) begin
        if (refill) begin
            tag   <= req_tag;
            maddr <= {req_tag, {cache_pkg::OFFSET_BITS{1'b0}}};
        end
        if (filling && mbeat) begin
            line[fill_cnt] <= mrdata;
        end
        if (serve) begin
            rdata <= line[req_word];
        end
    end

    // The memory must deliver a whole line before it acknowledges the burst.
    a_burst_length: assert property (
        @(posedge aclk) disable iff (rst)
        mreq && mack |-> mbeat && (int'(fill_cnt) == LINE_WORDS - 1)
    );

endmodule

//--- verilog/req_slice.sv
module req_slice #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     aclk,
    input  logic     rst,

    input  logic     up_req,
    input  payload_t up_payload,
    output logic     up_ack,

    output logic     dn_req,
    output payload_t dn_payload,
    input  logic     dn_ack
);

    logic take;

    // A new request is only taken once the previous cycle has fully closed.
    assign take = up_req && !dn_req && !dn_ack;

    always_ff @(posedge aclk) begin
        if (rst) begin
            dn_req <= 1'b0;
        end else if (take) begin
            dn_req <= 1'b1;
        end else if (dn_req && dn_ack && !up_req) begin
            dn_req <= 1'b0;  // Requester saw the ack and let go.
        end
    end

    always_ff @(posedge aclk) begin
        if (take) begin
            dn_payload <= up_payload;
        end
    end

    // The result side needs no staging, the path behind holds it while ack is high.
    assign up_ack = dn_ack;

    // The captured copy is only safe if the requester does not move the payload.
    a_payload_stable: assert property (
        @(posedge aclk) disable iff (rst)
        up_req && $past(up_req) |-> up_payload == $past(up_payload)
    );

endmodule

//--- verilog/cache_pkg.sv
package cache_pkg;

    // ####################
    // Line geometry
    // ####################

    // The instruction buffer keeps exactly one line of this shape.
    localparam int LINE_WORDS = 4;

    localparam int WORD_BYTES = bus_pkg::DATA_W / 8;

    // Byte offset inside a word.
    localparam int BYTE_BITS = $clog2(WORD_BYTES);

    // Word select inside a line.
    localparam int WORD_BITS = $clog2(LINE_WORDS);

    // Full offset inside a line, bytes and words together.
    localparam int OFFSET_BITS = WORD_BITS + BYTE_BITS;

    // Everything above the line offset identifies the line.
    localparam int TAG_BITS = bus_pkg::ADDR_W - OFFSET_BITS;

endpackage

//--- verilog/bus_pkg.sv
package bus_pkg;

    // ####################
    // Widths
    // ####################

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;  // One strobe per byte lane.

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;

    // ####################
    // Encodings
    // ####################

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_t;

    // Which path owns the memory port.
    typedef enum logic {
        SRC_INSTR = 1'b0,
        SRC_DATA  = 1'b1
    } src_t;

    // ####################
    // Request payloads
    // ####################

    typedef struct packed {
        addr_t addr;
    } ireq_t;

    typedef struct packed {
        addr_t addr;
        logic  we;
        word_t wdata;
        size_t size;
        logic  sgn;  // Sign-extend narrow loads.
    } dreq_t;

endpackage
